// ==== design/rpPkg.sv ====
/*
 * rpPkg
 * Register selects, drive type codes, drive geometry limits,
 * calculator state codes and the disk-address register layout
 */
`default_nettype none

package rpPkg;

   //////////////////////////////
   // Register selects
   //////////////////////////////

   // Desired cylinder
   localparam logic [1:0] selDca  = 2'd0;
   // Track and sector word
   localparam logic [1:0] selDa   = 2'd1;
   // Control, carries GO
   localparam logic [1:0] selCtrl = 2'd2;
   // Drive type select
   localparam logic [1:0] selType = 2'd3;

   // GO bit in a control write
   localparam int ctrlGo = 0;

   //////////////////////////////
   // Drive types and geometry
   //////////////////////////////

   localparam logic [1:0] typeRp04 = 2'd0;
   localparam logic [1:0] typeRp06 = 2'd1;
   localparam logic [1:0] typeRp07 = 2'd2;

   // Highest track, sector and cylinder per type
   localparam logic [5:0] rp04TrkMax = 6'd18;
   localparam logic [5:0] rp04SecMax = 6'd19;
   localparam logic [9:0] rp04CylMax = 10'd410;

   localparam logic [5:0] rp06TrkMax = 6'd18;
   localparam logic [5:0] rp06SecMax = 6'd19;
   localparam logic [9:0] rp06CylMax = 10'd814;

   localparam logic [5:0] rp07TrkMax = 6'd31;
   localparam logic [5:0] rp07SecMax = 6'd42;
   localparam logic [9:0] rp07CylMax = 10'd629;

   // Linear SD sector address width
   localparam int lsaWidth = 21;

   // Address calculator states
   localparam logic [1:0] calcIdle  = 2'd0;
   localparam logic [1:0] calcTrack = 2'd1;
   localparam logic [1:0] calcSect  = 2'd2;
   localparam logic [1:0] calcWord  = 2'd3;

   // Disk-address register, raw for writes, fields for decode
   typedef union packed {
      logic [15:0] raw;
      struct packed {
         logic [1:0] spareHi;
         logic [5:0] track;
         logic [1:0] spareLo;
         logic [5:0] sector;
      } fields;
   } rpDaWord;

endpackage

`default_nettype wire

// ==== design/rpGeometry.sv ====
/*
 * rpGeometry
 * Drive type to geometry lookup and disk address range check
 */
`default_nettype none
`timescale 1ns/1ps

module rpGeometry
(
   input  wire  [1:0]         driveType,
   input  wire  [9:0]         cylinder,
   input  wire  rpPkg::rpDaWord da,
   output logic [5:0]         trkMax,
   output logic [5:0]         secMax,
   output logic               addrValid
);

   // Highest legal cylinder for the selected type
   logic [9:0] cylMax;

   //////////////////////////////
   // Geometry lookup
   //////////////////////////////

   always_comb
   begin
      case (driveType)
         rpPkg::typeRp04:
         begin
            trkMax = rpPkg::rp04TrkMax;
            secMax = rpPkg::rp04SecMax;
            cylMax = rpPkg::rp04CylMax;
         end
         rpPkg::typeRp07:
         begin
            trkMax = rpPkg::rp07TrkMax;
            secMax = rpPkg::rp07SecMax;
            cylMax = rpPkg::rp07CylMax;
         end
         // RP06, and the spare code treated as RP06
         default:
         begin
            trkMax = rpPkg::rp06TrkMax;
            secMax = rpPkg::rp06SecMax;
            cylMax = rpPkg::rp06CylMax;
         end
      endcase
   end

   // All three address parts within limits
   assign addrValid = (cylinder <= cylMax) &&
                      (da.fields.track <= trkMax) &&
                      (da.fields.sector <= secMax);

endmodule

`default_nettype wire

// ==== design/rpAddrCalc.sv ====
/*
 * rpAddrCalc
 * Serial CHS to linear SD sector address calculator, SIMH layout
 * Multiplies by repeated addition through a single adder
 */
`default_nettype none
`timescale 1ns/1ps

module rpAddrCalc
(
   input  wire                        clk,
   input  wire                        rpADRSTRT,
   input  wire                        calcStart,
   input  wire  [5:0]                 trkMax,
   input  wire  [5:0]                 secMax,
   input  wire  [9:0]                 cylinder,
   input  wire  [5:0]                 track,
   input  wire  [5:0]                 sector,
   output logic [rpPkg::lsaWidth-1:0] lsa,
   output logic                       calcBusy
);

   logic [1:0]                 state;
   // Remaining additions in the current phase
   logic [5:0]                 loop;
   // Running sum and the value being multiplied
   logic [rpPkg::lsaWidth-1:0] sum;
   logic [rpPkg::lsaWidth-1:0] temp;
   // Second operand of the shared adder
   logic [rpPkg::lsaWidth-1:0] addend;
   logic [rpPkg::lsaWidth-1:0] adderOut;

   //////////////////////////////
   // Shared adder
   //////////////////////////////

   always_comb
   begin
      case (state)
         // Track folded in once the multiply is done
         rpPkg::calcTrack:
            addend = (loop == 6'd0) ? {{(rpPkg::lsaWidth-6){1'b0}}, track} : temp;
         // Sector folded in the same way
         rpPkg::calcSect:
            addend = (loop == 6'd0) ? {{(rpPkg::lsaWidth-6){1'b0}}, sector} : temp;
         // Doubling, two SD sectors per disk sector
         rpPkg::calcWord:
            addend = sum;
         default:
            addend = temp;
      endcase
   end

   assign adderOut = sum + addend;

   //////////////////////////////
   // Sequencer
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpADRSTRT)
      begin
         state <= rpPkg::calcIdle;
         loop  <= 6'd0;
         sum   <= '0;
         temp  <= '0;
      end
      else
      begin
         case (state)
            rpPkg::calcIdle:
            begin
               if (calcStart)
               begin
                  sum   <= '0;
                  temp  <= {{(rpPkg::lsaWidth-10){1'b0}}, cylinder};
                  loop  <= trkMax + 6'd1;
                  state <= rpPkg::calcTrack;
               end
            end
            // cylinder * (trkMax+1) + track
            rpPkg::calcTrack:
            begin
               if (loop == 6'd0)
               begin
                  sum   <= '0;
                  temp  <= adderOut;
                  loop  <= secMax + 6'd1;
                  state <= rpPkg::calcSect;
               end
               else
               begin
                  sum  <= adderOut;
                  loop <= loop - 6'd1;
               end
            end
            // ... * (secMax+1) + sector
            rpPkg::calcSect:
            begin
               sum <= adderOut;
               if (loop == 6'd0)
                  state <= rpPkg::calcWord;
               else
                  loop <= loop - 6'd1;
            end
            // Final doubling, back to idle
            default:
            begin
               sum   <= adderOut;
               state <= rpPkg::calcIdle;
            end
         endcase
      end
   end

   // Result holds in idle until the next start
   assign lsa      = sum;
   assign calcBusy = (state != rpPkg::calcIdle);

endmodule

`default_nettype wire

// ==== design/rpRegs.sv ====
/*
 * rpRegs
 * Cylinder, disk-address and drive-type registers, GO decode,
 * address error latch and SD transfer request pulse
 */
`default_nettype none
`timescale 1ns/1ps

module rpRegs
(
   input  wire                  clk,
   input  wire                  rpADRSTRT,
   input  wire                  regWrite,
   input  wire  [1:0]           regSel,
   input  wire  [15:0]          regData,
   input  wire                  addrValid,
   input  wire                  calcBusy,
   output logic [9:0]           dca,
   output rpPkg::rpDaWord       da,
   output logic [1:0]           driveType,
   output logic                 calcStart,
   output logic                 sdReq,
   output logic                 addrErr
);

   // Register writes only land while idle
   logic       writeOk;
   // GO seen on a control write
   logic       goWrite;
   // Accepted GO, idle and address checked
   logic       goIdle;
   // Busy delayed one cycle for the falling edge
   logic       calcBusyD;

   //////////////////////////////
   // Write decode
   //////////////////////////////

   assign writeOk = regWrite && !calcBusy;
   assign goWrite = regWrite && (regSel == rpPkg::selCtrl) && regData[rpPkg::ctrlGo];
   assign goIdle  = goWrite && !calcBusy;

   // Start in the same cycle as the GO write
   // Registers are frozen from the next cycle on
   assign calcStart = goIdle && addrValid;

   //////////////////////////////
   // Address registers
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpADRSTRT)
      begin
         dca       <= 10'd0;
         da.raw    <= 16'd0;
         driveType <= rpPkg::typeRp04;
      end
      else if (writeOk)
      begin
         case (regSel)
            rpPkg::selDca:
               dca <= regData[9:0];
            rpPkg::selDa:
               da.raw <= regData;
            rpPkg::selType:
               driveType <= regData[1:0];
            // Control writes hold no state here
            default:
            begin
               dca <= dca;
            end
         endcase
      end
   end

   //////////////////////////////
   // Error latch and SD request
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rpADRSTRT)
      begin
         addrErr   <= 1'b0;
         calcBusyD <= 1'b0;
         sdReq     <= 1'b0;
      end
      else
      begin
         // Bad address on GO latches, good GO clears
         if (goIdle)
            addrErr <= !addrValid;

         calcBusyD <= calcBusy;
         // One pulse, the cycle after busy drops
         sdReq     <= calcBusyD && !calcBusy;
      end
   end

endmodule

`default_nettype wire

// ==== design/rpDisk.sv ====
/*
 * rpDisk
 * RP disk-address front end, register file, geometry check
 * and linear SD sector address calculator
 */
`default_nettype none
`timescale 1ns/1ps

module rpDisk
(
   input  wire                        clk,
   input  wire                        rpADRSTRT,
   input  wire                        regWrite,
   input  wire  [1:0]                 regSel,
   input  wire  [15:0]                regData,
   output logic [rpPkg::lsaWidth-1:0] sdLsa,
   output logic                       busy,
   output logic                       addrErr,
   output logic                       sdReq
);

   // Register outputs
   logic [9:0]     dca;
   rpPkg::rpDaWord da;
   logic [1:0]     driveType;
   logic           calcStart;
   // Geometry for the selected drive
   logic [5:0]     trkMax;
   logic [5:0]     secMax;
   logic           addrValid;
   logic           calcBusy;

   //////////////////////////////
   // Blocks
   //////////////////////////////

   rpRegs i_rpRegs
   (
      .clk       (clk),
      .rpADRSTRT (rpADRSTRT),
      .regWrite  (regWrite),
      .regSel    (regSel),
      .regData   (regData),
      .addrValid (addrValid),
      .calcBusy  (calcBusy),
      .dca       (dca),
      .da        (da),
      .driveType (driveType),
      .calcStart (calcStart),
      .sdReq     (sdReq),
      .addrErr   (addrErr)
   );

   rpGeometry i_rpGeometry
   (
      .driveType (driveType),
      .cylinder  (dca),
      .da        (da),
      .trkMax    (trkMax),
      .secMax    (secMax),
      .addrValid (addrValid)
   );

   // Track and sector taken from the field view
   rpAddrCalc i_rpAddrCalc
   (
      .clk       (clk),
      .rpADRSTRT (rpADRSTRT),
      .calcStart (calcStart),
      .trkMax    (trkMax),
      .secMax    (secMax),
      .cylinder  (dca),
      .track     (da.fields.track),
      .sector    (da.fields.sector),
      .lsa       (sdLsa),
      .calcBusy  (calcBusy)
   );

   assign busy = calcBusy;

endmodule

`default_nettype wire

// ==== bench/rpDisk_assertions.sv ====
/*
 * rpDiskAssertions
 * Bound checks on the SD request pulse, busy and address error
 */
`default_nettype none
`timescale 1ns/1ps

module rpDiskAssertions
(
   input wire clk,
   input wire rpADRSTRT,
   input wire busy,
   input wire addrErr,
   input wire sdReq
);

   // Request is a single-cycle pulse
   reqOneCycle: assert property (@(posedge clk) disable iff (rpADRSTRT)
      sdReq |=> !sdReq)
      else $error("sdReq held high for more than one cycle");

   // Request only on the cycle after busy has dropped
   reqAfterBusy: assert property (@(posedge clk) disable iff (rpADRSTRT)
      sdReq |-> (!$past(busy) && $past(busy, 2)))
      else $error("sdReq without a preceding fall of busy");

   // Rejected address never starts the calculator
   errNotBusy: assert property (@(posedge clk) disable iff (rpADRSTRT)
      !(addrErr && busy))
      else $error("addrErr and busy high together");

endmodule

// Attach to every rpDisk instance
bind rpDisk rpDiskAssertions i_rpDiskAssertions
(
   .clk       (clk),
   .rpADRSTRT (rpADRSTRT),
   .busy      (busy),
   .addrErr   (addrErr),
   .sdReq     (sdReq)
);

`default_nettype wire

// ==== bench/rpDiskTb.sv ====
/*
 * rpDiskTb
 * Directed tests for the RP disk-address front end
 * Linear address results, range errors and busy lockout
 */
`default_nettype none
`timescale 1ns/1ps

module rpDiskTb;

   // Run budget, 40 tests of up to 90 cycles
   localparam int cycleLimit   = 40 * 90;
   // Longest single wait for sdReq, RP07 worst case plus margin
   localparam int reqWaitLimit = 100;
   localparam int randomCount  = 20;

   logic                       clk;
   logic                       rpADRSTRT;
   logic                       regWrite;
   logic [1:0]                 regSel;
   logic [15:0]                regData;
   logic [rpPkg::lsaWidth-1:0] sdLsa;
   logic                       busy;
   logic                       addrErr;
   logic                       sdReq;

   int                         cycleCount;
   int                         testErrors;
   int                         passCount;
   int                         failCount;
   string                      testName;
   logic [31:0]                rngState;

   rpDisk i_rpDisk
   (
      .clk       (clk),
      .rpADRSTRT (rpADRSTRT),
      .regWrite  (regWrite),
      .regSel    (regSel),
      .regData   (regData),
      .sdLsa     (sdLsa),
      .busy      (busy),
      .addrErr   (addrErr),
      .sdReq     (sdReq)
   );

   // 8 ns clock
   always
   begin
      #4;
      clk = ~clk;
   end

   //////////////////////////////
   // Geometry and reference model
   //////////////////////////////

   function automatic int trkMaxOf(input logic [1:0] driveType);
      case (driveType)
         rpPkg::typeRp04: return int'(rpPkg::rp04TrkMax);
         rpPkg::typeRp07: return int'(rpPkg::rp07TrkMax);
         default:         return int'(rpPkg::rp06TrkMax);
      endcase
   endfunction

   function automatic int secMaxOf(input logic [1:0] driveType);
      case (driveType)
         rpPkg::typeRp04: return int'(rpPkg::rp04SecMax);
         rpPkg::typeRp07: return int'(rpPkg::rp07SecMax);
         default:         return int'(rpPkg::rp06SecMax);
      endcase
   endfunction

   function automatic int cylMaxOf(input logic [1:0] driveType);
      case (driveType)
         rpPkg::typeRp04: return int'(rpPkg::rp04CylMax);
         rpPkg::typeRp07: return int'(rpPkg::rp07CylMax);
         default:         return int'(rpPkg::rp06CylMax);
      endcase
   endfunction

   // Two SD sectors per disk sector
   function automatic int expectedLsa(input logic [1:0] driveType, input int cyl,
                                      input int trk, input int sec);
      int tracks;
      int sectors;
      tracks  = trkMaxOf(driveType) + 1;
      sectors = secMaxOf(driveType) + 1;
      return 2 * ((cyl * tracks + trk) * sectors + sec);
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Value in 0 .. range-1
   task automatic nextRandom(input int range, output int value);
      rngState = xorshift32(rngState);
      value    = int'(rngState[30:0]) % range;
   endtask

   //////////////////////////////
   // Bus helpers
   //////////////////////////////

   // Inputs change 1 ns after the edge, outputs read there too
   task automatic stepCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic writeReg(input logic [1:0] sel, input logic [15:0] data);
      regSel   = sel;
      regData  = data;
      regWrite = 1'b1;
      stepCycle();
      regWrite = 1'b0;
      regData  = 16'd0;
   endtask

   task automatic loadAddress(input logic [1:0] driveType, input int cyl,
                              input int trk, input int sec);
      rpPkg::rpDaWord daWord;
      daWord.raw           = 16'd0;
      daWord.fields.track  = 6'(trk);
      daWord.fields.sector = 6'(sec);
      writeReg(rpPkg::selType, {14'd0, driveType});
      writeReg(rpPkg::selDca, {6'd0, 10'(cyl)});
      writeReg(rpPkg::selDa, daWord.raw);
   endtask

   task automatic issueGo();
      writeReg(rpPkg::selCtrl, 16'(1 << rpPkg::ctrlGo));
   endtask

   // Wait for the request pulse and grab the address with it
   task automatic waitForReq(output bit seen, output int lsaAtReq);
      int waited;
      seen     = 1'b0;
      lsaAtReq = 0;
      waited   = 0;
      while (!seen && waited < reqWaitLimit)
      begin
         stepCycle();
         waited++;
         if (sdReq)
         begin
            seen     = 1'b1;
            lsaAtReq = int'(sdLsa);
         end
      end
   endtask

   task automatic countReqs(input int cycles, output int count);
      int i;
      count = 0;
      for (i = 0; i < cycles; i++)
      begin
         stepCycle();
         if (sdReq)
            count++;
      end
   endtask

   //////////////////////////////
   // Reporting
   //////////////////////////////

   task automatic beginTest(input string name);
      testName   = name;
      testErrors = 0;
   endtask

   task automatic reportValue(input string what, input int expected, input int actual);
      $display("FAILED %s: %s expected %0d actual %0d", testName, what, expected, actual);
      testErrors++;
   endtask

   task automatic reportProblem(input string what);
      $display("Problem in %s: %s", testName, what);
      testErrors++;
   endtask

   task automatic endTest();
      if (testErrors == 0)
      begin
         passCount++;
         $display("PASS  %s", testName);
      end
      else
      begin
         failCount++;
         $display("FAIL  %s, %0d mismatches", testName, testErrors);
      end
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic testReset();
      beginTest("reset state");
      if (busy)
         reportValue("busy", 0, 1);
      if (sdReq)
         reportValue("sdReq", 0, 1);
      if (addrErr)
         reportValue("addrErr", 0, 1);
      if (int'(sdLsa) != 0)
         reportValue("sdLsa", 0, int'(sdLsa));
      endTest();
   endtask

   // Load, GO, then check the address seen with sdReq
   task automatic runTransfer(input string name, input logic [1:0] driveType,
                              input int cyl, input int trk, input int sec);
      bit seen;
      int lsaAtReq;
      int expLsa;
      beginTest(name);
      expLsa = expectedLsa(driveType, cyl, trk, sec);
      loadAddress(driveType, cyl, trk, sec);
      issueGo();
      if (!busy)
         reportProblem("busy did not rise after GO");
      waitForReq(seen, lsaAtReq);
      if (!seen)
         reportProblem("no sdReq within the wait limit");
      else if (lsaAtReq != expLsa)
         reportValue("sdLsa", expLsa, lsaAtReq);
      if (busy)
         reportProblem("busy still high with sdReq");
      if (addrErr)
         reportValue("addrErr", 0, 1);
      endTest();
   endtask

   task automatic testCorners(input logic [1:0] driveType, input string label);
      runTransfer({label, " zero address"}, driveType, 0, 0, 0);
      runTransfer({label, " max address"}, driveType, cylMaxOf(driveType),
                  trkMaxOf(driveType), secMaxOf(driveType));
   endtask

   task automatic testRandom();
      int i;
      int pick;
      int cyl;
      int trk;
      int sec;
      logic [1:0] driveType;
      for (i = 0; i < randomCount; i++)
      begin
         nextRandom(3, pick);
         driveType = (pick == 0) ? rpPkg::typeRp04 :
                     (pick == 1) ? rpPkg::typeRp06 : rpPkg::typeRp07;
         nextRandom(cylMaxOf(driveType) + 1, cyl);
         nextRandom(trkMaxOf(driveType) + 1, trk);
         nextRandom(secMaxOf(driveType) + 1, sec);
         runTransfer($sformatf("random %0d", i), driveType, cyl, trk, sec);
      end
   endtask

   // Bad address latches addrErr, next good GO clears it
   task automatic testRangeError(input string name, input logic [1:0] driveType,
                                 input int cyl, input int trk, input int sec);
      int reqs;
      bit seen;
      int lsaAtReq;
      int expLsa;
      beginTest(name);
      loadAddress(driveType, cyl, trk, sec);
      issueGo();
      if (!addrErr)
         reportValue("addrErr", 1, 0);
      if (busy)
         reportProblem("busy rose on an out-of-range address");
      countReqs(trkMaxOf(driveType) + secMaxOf(driveType) + 10, reqs);
      if (reqs != 0)
         reportValue("sdReq count", 0, reqs);
      if (!addrErr)
         reportProblem("addrErr did not stay set");
      expLsa = expectedLsa(driveType, 1, 1, 1);
      loadAddress(driveType, 1, 1, 1);
      issueGo();
      if (addrErr)
         reportValue("addrErr after valid GO", 0, 1);
      waitForReq(seen, lsaAtReq);
      if (!seen)
         reportProblem("no sdReq after the valid GO");
      else if (lsaAtReq != expLsa)
         reportValue("sdLsa", expLsa, lsaAtReq);
      endTest();
   endtask

   // Register writes and a second GO during busy change nothing
   task automatic testBusyLockout();
      rpPkg::rpDaWord other;
      bit seen;
      int lsaAtReq;
      int expLsa;
      int reqs;
      beginTest("writes and GO while busy");
      expLsa = expectedLsa(rpPkg::typeRp06, 100, 5, 7);
      loadAddress(rpPkg::typeRp06, 100, 5, 7);
      issueGo();
      other.raw           = 16'd0;
      other.fields.track  = 6'd2;
      other.fields.sector = 6'd3;
      writeReg(rpPkg::selDca, 16'd200);
      writeReg(rpPkg::selDa, other.raw);
      writeReg(rpPkg::selType, {14'd0, rpPkg::typeRp07});
      issueGo();
      if (!busy)
         reportProblem("busy dropped during the lockout writes");
      waitForReq(seen, lsaAtReq);
      if (!seen)
         reportProblem("no sdReq for the first GO");
      else if (lsaAtReq != expLsa)
         reportValue("sdLsa", expLsa, lsaAtReq);
      // A second GO that got through would show up here
      countReqs(trkMaxOf(rpPkg::typeRp06) + secMaxOf(rpPkg::typeRp06) + 10, reqs);
      if (reqs != 0)
         reportValue("extra sdReq count", 0, reqs);
      // Same registers again, so same result
      issueGo();
      waitForReq(seen, lsaAtReq);
      if (!seen)
         reportProblem("no sdReq for the repeat GO");
      else if (lsaAtReq != expLsa)
         reportValue("sdLsa on repeat", expLsa, lsaAtReq);
      endTest();
   endtask

   //////////////////////////////
   // Watchdog and main sequence
   //////////////////////////////

   initial
   begin
      cycleCount = 0;
      while (cycleCount < cycleLimit)
      begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout after %0d cycles, tests did not finish", cycleLimit);
      $display("Errors found");
      $finish;
   end

   initial
   begin
      clk        = 1'b0;
      rpADRSTRT  = 1'b1;
      regWrite   = 1'b0;
      regSel     = 2'd0;
      regData    = 16'd0;
      rngState   = 32'hfac1_5b9f;
      passCount  = 0;
      failCount  = 0;
      testErrors = 0;
      testName   = "";
      repeat (4) @(posedge clk);
      #1;
      rpADRSTRT = 1'b0;

      testReset();
      testCorners(rpPkg::typeRp04, "RP04");
      testCorners(rpPkg::typeRp06, "RP06");
      testCorners(rpPkg::typeRp07, "RP07");
      testRandom();
      testRangeError("track out of range", rpPkg::typeRp04, 10,
                     trkMaxOf(rpPkg::typeRp04) + 1, 0);
      testRangeError("sector out of range", rpPkg::typeRp07, 10, 0,
                     secMaxOf(rpPkg::typeRp07) + 1);
      testRangeError("cylinder out of range", rpPkg::typeRp06,
                     cylMaxOf(rpPkg::typeRp06) + 1, 0, 0);
      testBusyLockout();

      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rpDisk.f ====
design/rpPkg.sv
design/rpGeometry.sv
design/rpAddrCalc.sv
design/rpRegs.sv
design/rpDisk.sv
bench/rpDisk_assertions.sv
bench/rpDiskTb.sv

// ==== Makefile ====
# Verilator build and run for the RP disk-address front end

VERILATOR ?= verilator
TOP       ?= rpDiskTb
FILELIST  ?= rpDisk.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Errors found

SOURCES := $(wildcard design/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A crash or a failed assertion also counts as a failure
run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	   echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	   echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
